// ==== exec_params.svh ====
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Datapath width of operands and results
`define DATA_W 32

// General purpose register file
`define NUM_REGS 32
`define REG_IDX_W 5

`endif

// ==== exec_pkg.sv ====
package exec_pkg;

	// Major opcode field in instr[30:25]
	typedef enum logic [5:0] {
		LWI     = 6'b000010,
		SWI     = 6'b001010,
		TY_LS   = 6'b011100, // Register form load/store
		TY_BASE = 6'b100000, // ALU_1 group
		MOVI    = 6'b100010,
		JJ      = 6'b100100,
		TY_B    = 6'b100110, // beq/bne group
		ADDI    = 6'b101000,
		XORI    = 6'b101011,
		ORI     = 6'b101100
	} opcode_t;

	// Sub-opcode of TY_BASE in instr[4:0]
	typedef enum logic [4:0] {
		ADD   = 5'b00000,
		SUB   = 5'b00001,
		AND   = 5'b00010,
		XOR   = 5'b00011,
		OR    = 5'b00100,
		SLLI  = 5'b01000,
		SRLI  = 5'b01001,
		ROTRI = 5'b01011
	} sub_base_t;

	// Sub-opcode of TY_LS in instr[7:0]
	typedef enum logic [7:0] {
		LW = 8'b00000010,
		SW = 8'b00001010
	} sub_ls_t;

	// Operation handed from decode to the ALU and result stage
	typedef enum logic [3:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SRL,
		OP_SLL,
		OP_ROR,
		OP_PASS,
		OP_LOAD_ADDR,
		OP_STORE_ADDR,
		OP_CMP
	} alu_op_t;

endpackage

// ==== exec_if.sv ====
`timescale 1ns/1ns
`include "exec_params.svh"

interface exec_if import exec_pkg::*; ();
	logic valid;
	alu_op_t op;
	logic [`DATA_W-1:0] src1;
	logic [`DATA_W-1:0] src2;
	logic [`REG_IDX_W-1:0] rd; // Destination register index
	logic [`DATA_W-1:0] store_data;

	logic [`DATA_W-1:0] result;
	logic overflow;
	logic zero;

	// Result comes back to decode for forwarding
	modport issue (output valid, op, src1, src2, rd, store_data, input result);

	modport execute (input valid, op, src1, src2, rd, store_data,
		output result, overflow, zero);

	modport retire (input valid, op, src1, src2, rd, store_data, result, overflow, zero);

endinterface

// ==== reg_file.sv ====
`timescale 1ns/1ns
`include "exec_params.svh"

module reg_file (
	input  logic clk,
	input  logic reset,
	input  logic [`REG_IDX_W-1:0] raddr_a,
	input  logic [`REG_IDX_W-1:0] raddr_b,
	input  logic [`REG_IDX_W-1:0] raddr_c,
	output logic [`DATA_W-1:0] rdata_a,
	output logic [`DATA_W-1:0] rdata_b,
	output logic [`DATA_W-1:0] rdata_c,
	input  logic we,
	input  logic [`REG_IDX_W-1:0] waddr,
	input  logic [`DATA_W-1:0] wdata
);

	logic [`DATA_W-1:0] regs [`NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// Reads see the old value during a write and decode forwards the new one
	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];
	assign rdata_c = regs[raddr_c]; // rt port for store data and branch operand

endmodule

// ==== inst_decode.sv ====
`timescale 1ns/1ns
`include "exec_params.svh"

module inst_decode import exec_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic instr_valid,
	input  logic [31:0] instr,
	output logic [`REG_IDX_W-1:0] raddr_a,
	output logic [`REG_IDX_W-1:0] raddr_b,
	output logic [`REG_IDX_W-1:0] raddr_c,
	input  logic [`DATA_W-1:0] rdata_a,
	input  logic [`DATA_W-1:0] rdata_b,
	input  logic [`DATA_W-1:0] rdata_c,
	output logic illegal,
	exec_if.issue id
);

	opcode_t opcode;
	sub_base_t sub_base;
	sub_ls_t sub_ls;
	logic [`REG_IDX_W-1:0] rt;
	logic [`REG_IDX_W-1:0] ra;
	logic [`REG_IDX_W-1:0] rb;
	logic [`DATA_W-1:0] imm15_sext;
	logic [`DATA_W-1:0] imm15_zext;
	logic [`DATA_W-1:0] imm20_sext;
	logic fwd_ok;
	logic [`DATA_W-1:0] opnd_ra;
	logic [`DATA_W-1:0] opnd_rb;
	logic [`DATA_W-1:0] opnd_rt;
	alu_op_t dec_op;
	logic dec_legal;
	logic [`DATA_W-1:0] dec_src1;
	logic [`DATA_W-1:0] dec_src2;

	assign opcode   = opcode_t'(instr[30:25]);
	assign sub_base = sub_base_t'(instr[4:0]);
	assign sub_ls   = sub_ls_t'(instr[7:0]);
	assign rt = instr[24:20];
	assign ra = instr[19:15];
	assign rb = instr[14:10];

	assign imm15_sext = {{(`DATA_W-15){instr[14]}}, instr[14:0]};
	assign imm15_zext = {{(`DATA_W-15){1'b0}}, instr[14:0]};
	assign imm20_sext = {{(`DATA_W-20){instr[19]}}, instr[19:0]};

	assign raddr_a = ra;
	assign raddr_b = rb;
	assign raddr_c = rt;

	// Instruction in the decode register writes back on the edge that samples this one
	assign fwd_ok = id.valid && (id.op != OP_STORE_ADDR) && (id.op != OP_CMP);

	assign opnd_ra = (fwd_ok && id.rd == ra) ? id.result : rdata_a;
	assign opnd_rb = (fwd_ok && id.rd == rb) ? id.result : rdata_b;
	assign opnd_rt = (fwd_ok && id.rd == rt) ? id.result : rdata_c;

	always_comb begin
		dec_op    = OP_ADD;
		dec_legal = 1'b1;
		dec_src1  = opnd_ra;
		dec_src2  = opnd_rb;
		case (opcode)
			TY_BASE: begin
				case (sub_base)
					ADD:     dec_op = OP_ADD;
					SUB:     dec_op = OP_SUB;
					AND:     dec_op = OP_AND;
					OR:      dec_op = OP_OR;
					XOR:     dec_op = OP_XOR;
					SRLI:    dec_op = OP_SRL;
					SLLI:    dec_op = OP_SLL;
					ROTRI:   dec_op = OP_ROR;
					default: dec_legal = 1'b0;
				endcase
			end
			ADDI: dec_src2 = imm15_sext;
			ORI: begin
				dec_op   = OP_OR;
				dec_src2 = imm15_zext;
			end
			XORI: begin
				dec_op   = OP_XOR;
				dec_src2 = imm15_zext;
			end
			MOVI: begin
				dec_op   = OP_PASS;
				dec_src1 = imm20_sext;
			end
			LWI: begin
				dec_op   = OP_LOAD_ADDR;
				dec_src2 = imm15_sext;
			end
			SWI: begin
				dec_op   = OP_STORE_ADDR;
				dec_src2 = imm15_sext;
			end
			TY_LS: begin
				case (sub_ls)
					LW:      dec_op = OP_LOAD_ADDR;
					SW:      dec_op = OP_STORE_ADDR;
					default: dec_legal = 1'b0;
				endcase
			end
			TY_B: begin
				dec_op   = OP_CMP; // rt against ra
				dec_src1 = opnd_rt;
				dec_src2 = opnd_ra;
			end
			JJ:      dec_legal = 1'b0; // Jumps not handled here
			default: dec_legal = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			id.valid <= 1'b0;
			illegal  <= 1'b0;
		end else begin
			id.valid <= instr_valid && dec_legal;
			illegal  <= instr_valid && !dec_legal;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			id.op         <= dec_op;
			id.src1       <= dec_src1;
			id.src2       <= dec_src2;
			id.rd         <= rt;
			id.store_data <= opnd_rt;
		end
	end

endmodule

// ==== alu.sv ====
`timescale 1ns/1ns
`include "exec_params.svh"

module alu import exec_pkg::*; (
	exec_if.execute ex
);

	localparam int SHAMT_W = $clog2(`DATA_W);

	logic [SHAMT_W-1:0] shamt;
	logic [2*`DATA_W-1:0] rotate;
	logic [`DATA_W-1:0] res;
	logic ovf;
	logic a; // Carry or borrow into the sign bit
	logic b; // Carry or borrow out of the sign bit

	assign shamt = ex.src2[SHAMT_W-1:0];

	always_comb begin
		a      = 1'b0;
		b      = 1'b0;
		rotate = '0;
		res    = '0;
		ovf    = 1'b0;
		case (ex.op)
			OP_ADD, OP_LOAD_ADDR, OP_STORE_ADDR: begin
				{a, res[`DATA_W-2:0]} = ex.src1[`DATA_W-2:0] + ex.src2[`DATA_W-2:0];
				{b, res[`DATA_W-1]} = ex.src1[`DATA_W-1] + ex.src2[`DATA_W-1] + a;
				ovf = a ^ b;
			end
			OP_SUB: begin
				{a, res[`DATA_W-2:0]} = ex.src1[`DATA_W-2:0] - ex.src2[`DATA_W-2:0];
				{b, res[`DATA_W-1]} = ex.src1[`DATA_W-1] - ex.src2[`DATA_W-1] - a;
				ovf = a ^ b;
			end
			OP_AND: begin
				res = ex.src1 & ex.src2;
			end
			OP_OR: begin
				res = ex.src1 | ex.src2;
			end
			OP_XOR: begin
				res = ex.src1 ^ ex.src2;
			end
			OP_SRL: begin
				res = ex.src1 >> shamt;
			end
			OP_SLL: begin
				res = ex.src1 << shamt;
			end
			OP_ROR: begin
				rotate = {ex.src1, ex.src1} >> shamt;
				res    = rotate[`DATA_W-1:0];
			end
			OP_PASS: begin
				res = ex.src1; // Immediate already extended by decode
			end
			OP_CMP: begin
				res = ex.src1 ^ ex.src2; // Zero when operands are equal
			end
			default: begin
				res = 'x;
			end
		endcase
	end

	assign ex.result   = res;
	assign ex.overflow = ovf;
	assign ex.zero     = (res == '0);

endmodule

// ==== result_stage.sv ====
`timescale 1ns/1ns
`include "exec_params.svh"

module result_stage import exec_pkg::*; (
	input  logic clk,
	input  logic reset,
	exec_if.retire ex,
	input  logic illegal,
	output logic we,
	output logic [`REG_IDX_W-1:0] waddr,
	output logic [`DATA_W-1:0] wdata,
	output logic result_valid,
	output logic [`DATA_W-1:0] result,
	output logic overflow,
	output logic zero,
	output logic wb_en,
	output logic [`REG_IDX_W-1:0] wb_reg,
	output logic store_en,
	output logic [`DATA_W-1:0] store_data,
	output logic branch_valid,
	output logic illegal_instr
);

	logic is_store;
	logic is_cmp;

	assign is_store = ex.valid && (ex.op == OP_STORE_ADDR);
	assign is_cmp   = ex.valid && (ex.op == OP_CMP);

	// Register file takes the ALU result on the same edge as the output registers
	assign we    = ex.valid && !is_store && !is_cmp; // Overflow does not block write-back
	assign waddr = ex.rd;
	assign wdata = ex.result;

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid  <= 1'b0;
			wb_en         <= 1'b0;
			store_en      <= 1'b0;
			branch_valid  <= 1'b0;
			illegal_instr <= 1'b0;
		end else begin
			result_valid  <= ex.valid;
			wb_en         <= we;
			store_en      <= is_store;
			branch_valid  <= is_cmp;
			illegal_instr <= illegal;
		end
	end

	always_ff @(posedge clk) begin
		if (ex.valid) begin
			result     <= ex.result;
			overflow   <= ex.overflow;
			zero       <= ex.zero;
			wb_reg     <= ex.rd;
			store_data <= ex.store_data;
		end
	end

endmodule

// ==== exec_top.sv ====
`timescale 1ns/1ns
`include "exec_params.svh"

module exec_top (
	input  logic clk,
	input  logic reset,
	input  logic instr_valid,
	input  logic [31:0] instr,
	output logic result_valid,
	output logic [`DATA_W-1:0] result,
	output logic overflow,
	output logic zero,
	output logic wb_en,
	output logic [`REG_IDX_W-1:0] wb_reg,
	output logic store_en,
	output logic [`DATA_W-1:0] store_data,
	output logic branch_valid,
	output logic illegal_instr
);

	logic [`REG_IDX_W-1:0] raddr_a;
	logic [`REG_IDX_W-1:0] raddr_b;
	logic [`REG_IDX_W-1:0] raddr_c;
	logic [`DATA_W-1:0] rdata_a;
	logic [`DATA_W-1:0] rdata_b;
	logic [`DATA_W-1:0] rdata_c;
	logic rf_we;
	logic [`REG_IDX_W-1:0] rf_waddr;
	logic [`DATA_W-1:0] rf_wdata;
	logic dec_illegal;

	exec_if ex_bus ();

	inst_decode inst_decode_inst (
		.clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
		.raddr_a(raddr_a), .raddr_b(raddr_b), .raddr_c(raddr_c),
		.rdata_a(rdata_a), .rdata_b(rdata_b), .rdata_c(rdata_c),
		.illegal(dec_illegal), .id(ex_bus.issue)
	);

	reg_file reg_file_inst (
		.clk(clk), .reset(reset),
		.raddr_a(raddr_a), .raddr_b(raddr_b), .raddr_c(raddr_c),
		.rdata_a(rdata_a), .rdata_b(rdata_b), .rdata_c(rdata_c),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
	);

	alu alu_inst (.ex(ex_bus.execute));

	result_stage result_stage_inst (
		.clk(clk), .reset(reset), .ex(ex_bus.retire), .illegal(dec_illegal),
		.we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
		.result_valid(result_valid), .result(result), .overflow(overflow), .zero(zero),
		.wb_en(wb_en), .wb_reg(wb_reg), .store_en(store_en), .store_data(store_data),
		.branch_valid(branch_valid), .illegal_instr(illegal_instr)
	);

endmodule

// ==== tb_exec_top.sv ====
`timescale 1ns/1ns
`include "exec_params.svh"

module tb_exec_top import exec_pkg::*; ();

	localparam int N_SEED = `NUM_REGS;
	localparam int N_BASE = 200;
	localparam int N_IMM  = 120;
	localparam int N_LS   = 120;
	localparam int N_DEP  = 60;
	localparam int N_ILL  = 40;
	// One clock per test step plus two drain cycles per test
	localparam int TOTAL_STEPS = N_SEED + N_BASE + N_IMM + N_LS + N_DEP + N_ILL + `NUM_REGS + 12;

	typedef struct packed {
		logic rv;
		logic [31:0] res;
		logic ovf;
		logic zr;
		logic wb;
		logic [4:0] wreg;
		logic st;
		logic [31:0] sdata;
		logic br;
		logic ill;
	} expect_t;

	logic clk;
	logic reset;
	logic instr_valid;
	logic [31:0] instr;
	logic result_valid;
	logic [`DATA_W-1:0] result;
	logic overflow;
	logic zero;
	logic wb_en;
	logic [`REG_IDX_W-1:0] wb_reg;
	logic store_en;
	logic [`DATA_W-1:0] store_data;
	logic branch_valid;
	logic illegal_instr;

	logic [31:0] model_regs [`NUM_REGS];
	expect_t pending [$]; // Issued but not yet compared
	logic [4:0] base_subs [8];
	int test_errs;
	int total_errs;
	int tests_passed;
	int tests_failed;

	exec_top exec_top_inst (.*);

	always #20 clk = ~clk;

	initial begin : watchdog
		#((TOTAL_STEPS + 20) * 40);
		$display("Timeout: the run did not reach its end in the expected time");
		$display("Test failed");
		$finish;
	end

	function automatic logic [32:0] add_model(input logic [31:0] x, input logic [31:0] y);
		logic [31:0] s;
		s = x + y;
		return {(x[31] == y[31]) && (s[31] != x[31]), s}; // Signed overflow on top
	endfunction

	function automatic logic [32:0] sub_model(input logic [31:0] x, input logic [31:0] y);
		logic [31:0] d;
		d = x - y;
		return {(x[31] != y[31]) && (d[31] != x[31]), d};
	endfunction

	function automatic logic supported_opcode(input logic [5:0] opc);
		case (opc)
			TY_BASE, ADDI, ORI, XORI, MOVI, LWI, SWI, TY_LS, TY_B: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [4:0] rand_reg();
		logic [31:0] r;
		r = $urandom;
		return r[4:0];
	endfunction

	function automatic logic [31:0] with_fields(input logic [5:0] opc, input logic [4:0] rt,
		input logic [4:0] ra);
		logic [31:0] w;
		w = $urandom;
		w[30:25] = opc;
		w[24:20] = rt;
		w[19:15] = ra;
		return w;
	endfunction

	// Expected outputs of one instruction from the register model before it issues
	function automatic expect_t model_exec(input logic [31:0] w);
		expect_t e;
		logic [31:0] ra_v;
		logic [31:0] rb_v;
		logic [31:0] rt_v;
		logic [31:0] imm15_s;
		logic [31:0] imm15_z;
		logic [32:0] ar;
		logic [4:0] s;
		ra_v = model_regs[w[19:15]];
		rb_v = model_regs[w[14:10]];
		rt_v = model_regs[w[24:20]];
		imm15_s = {{17{w[14]}}, w[14:0]};
		imm15_z = {17'b0, w[14:0]};
		s = rb_v[4:0];
		ar = '0;
		e = '0;
		e.rv = 1'b1;
		e.wb = 1'b1;
		e.wreg = w[24:20];
		case (w[30:25])
			TY_BASE: begin
				case (w[4:0])
					ADD:     ar = add_model(ra_v, rb_v);
					SUB:     ar = sub_model(ra_v, rb_v);
					AND:     ar[31:0] = ra_v & rb_v;
					OR:      ar[31:0] = ra_v | rb_v;
					XOR:     ar[31:0] = ra_v ^ rb_v;
					SRLI:    ar[31:0] = ra_v >> s;
					SLLI:    ar[31:0] = ra_v << s;
					ROTRI:   ar[31:0] = (ra_v >> s) | (ra_v << (6'd32 - s));
					default: e = '0;
				endcase
			end
			ADDI: ar = add_model(ra_v, imm15_s);
			ORI:  ar[31:0] = ra_v | imm15_z;
			XORI: ar[31:0] = ra_v ^ imm15_z;
			MOVI: ar[31:0] = {{12{w[19]}}, w[19:0]};
			LWI:  ar = add_model(ra_v, imm15_s);
			SWI: begin
				ar = add_model(ra_v, imm15_s);
				e.wb = 1'b0;
				e.st = 1'b1;
				e.sdata = rt_v;
			end
			TY_LS: begin
				case (w[7:0])
					LW: ar = add_model(ra_v, rb_v);
					SW: begin
						ar = add_model(ra_v, rb_v);
						e.wb = 1'b0;
						e.st = 1'b1;
						e.sdata = rt_v;
					end
					default: e = '0;
				endcase
			end
			TY_B: begin
				ar[31:0] = rt_v ^ ra_v;
				e.wb = 1'b0;
				e.br = 1'b1;
			end
			default: e = '0;
		endcase
		if (e.rv) begin
			e.res = ar[31:0];
			e.ovf = ar[32];
			e.zr = (w[30:25] == TY_B) ? (rt_v == ra_v) : (ar[31:0] == 32'b0);
		end else begin
			e.ill = 1'b1;
		end
		return e;
	endfunction

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
			test_errs++;
		end
	endtask

	task automatic compare_outputs(input expect_t e);
		check_bit("result_valid", e.rv, result_valid);
		check_bit("wb_en", e.wb, wb_en);
		check_bit("store_en", e.st, store_en);
		check_bit("branch_valid", e.br, branch_valid);
		check_bit("illegal_instr", e.ill, illegal_instr);
		if (e.rv) begin
			check_word("result", e.res, result);
			check_bit("overflow", e.ovf, overflow);
			check_bit("zero", e.zr, zero);
		end
		if (e.wb)
			check_word("wb_reg", {27'b0, e.wreg}, {27'b0, wb_reg});
		if (e.st)
			check_word("store_data", e.sdata, store_data);
	endtask

	// Compares the instruction sampled two edges back and then drives the next one
	task automatic step(input logic valid, input logic [31:0] w, input expect_t e);
		expect_t due;
		@(posedge clk);
		#2;
		if (pending.size() == 2) begin
			due = pending.pop_front();
			compare_outputs(due);
		end
		instr_valid = valid;
		instr = w;
		pending.push_back(e);
	endtask

	task automatic issue(input logic [31:0] w);
		expect_t e;
		e = model_exec(w);
		if (e.wb)
			model_regs[e.wreg] = e.res;
		step(1'b1, w, e);
	endtask

	task automatic idle_cycle();
		step(1'b0, $urandom, '0);
	endtask

	task automatic end_test(input string name, input int count);
		idle_cycle();
		idle_cycle();
		$display("%s: %0d steps, %0d errors", name, count, test_errs);
		if (test_errs == 0)
			tests_passed++;
		else
			tests_failed++;
		total_errs += test_errs;
		test_errs = 0;
	endtask

	initial begin
		logic [31:0] w;
		logic [4:0] dest;
		int kind;
		void'($urandom(32'ha12f));
		clk = 1'b0;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		test_errs = 0;
		total_errs = 0;
		tests_passed = 0;
		tests_failed = 0;
		base_subs = '{ADD, SUB, AND, OR, XOR, SRLI, SLLI, ROTRI};
		for (int i = 0; i < `NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;

		check_bit("result_valid", 1'b0, result_valid);
		check_bit("wb_en", 1'b0, wb_en);
		check_bit("store_en", 1'b0, store_en);
		check_bit("branch_valid", 1'b0, branch_valid);
		check_bit("illegal_instr", 1'b0, illegal_instr);
		for (int i = 0; i < N_SEED; i++) begin
			issue(with_fields(MOVI, i[4:0], rand_reg()));
		end
		end_test("reset_and_movi_seed", N_SEED);

		for (int i = 0; i < N_BASE; i++) begin
			if ($urandom % 8 == 0) begin
				idle_cycle(); // Gap with garbage on instr
			end else begin
				w = with_fields(TY_BASE, rand_reg(), rand_reg());
				w[4:0] = base_subs[$urandom % 8];
				issue(w);
			end
		end
		end_test("base_type", N_BASE);

		for (int i = 0; i < N_IMM; i++) begin
			kind = $urandom % 3;
			w = with_fields(kind == 0 ? ADDI : (kind == 1 ? ORI : XORI), rand_reg(), rand_reg());
			issue(w);
		end
		end_test("immediate_forms", N_IMM);

		for (int i = 0; i < N_LS; i++) begin
			kind = $urandom % 5;
			case (kind)
				0: w = with_fields(LWI, rand_reg(), rand_reg());
				1: w = with_fields(SWI, rand_reg(), rand_reg());
				2, 3: begin
					w = with_fields(TY_LS, rand_reg(), rand_reg());
					w[7:0] = (kind == 2) ? LW : SW;
				end
				default: begin
					w = with_fields(TY_B, rand_reg(), rand_reg());
					if ($urandom % 4 == 0)
						w[19:15] = w[24:20]; // Equal operands
				end
			endcase
			issue(w);
		end
		end_test("load_store_branch", N_LS);

		dest = rand_reg();
		for (int i = 0; i < N_DEP; i++) begin
			kind = $urandom % 4;
			case (kind)
				0: begin
					w = with_fields(TY_BASE, rand_reg(), dest);
					w[4:0] = base_subs[$urandom % 8];
					if ($urandom % 2 == 0)
						w[14:10] = dest;
				end
				1: w = with_fields(ADDI, rand_reg(), dest);
				2: w = with_fields(XORI, rand_reg(), dest);
				default: w = with_fields(LWI, rand_reg(), dest);
			endcase
			issue(w);
			dest = w[24:20];
		end
		end_test("dependent_chain", N_DEP);

		for (int i = 0; i < N_ILL; i++) begin
			kind = $urandom % 4;
			w = $urandom;
			case (kind)
				0: begin
					while (supported_opcode(w[30:25]))
						w = $urandom;
				end
				1: begin
					w[30:25] = TY_BASE;
					w[4] = 1'b1; // Sub-opcodes 16 to 31 are unused
				end
				2: begin
					w[30:25] = TY_LS;
					w[7] = 1'b1;
				end
				default: w[30:25] = JJ;
			endcase
			issue(w);
		end
		for (int i = 0; i < `NUM_REGS; i++) begin
			w = with_fields(ORI, i[4:0], i[4:0]);
			w[14:0] = '0;
			issue(w);
		end
		end_test("illegal_and_readback", N_ILL + `NUM_REGS);

		$display("summary: %0d tests ok, %0d tests with errors, %0d mismatches",
			tests_passed, tests_failed, total_errs);
		if (tests_failed == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+.
exec_pkg.sv
exec_if.sv
reg_file.sv
inst_decode.sv
alu.sv
result_stage.sv
exec_top.sv
tb_exec_top.sv
